// ==== Bender.yml ====
package:
  name: frontend

sources:
  - hdl/frontend_pkg.sv
  - hdl/pre_fetch_stage.sv
  - hdl/fetch_stage.sv
  - hdl/branch_predictor.sv
  - hdl/inst_rom.sv
  - hdl/frontend_top.sv
  - target: test
    files:
      - test/frontend_asserts.sv
      - test/frontend_tb.sv

// ==== filelist.f ====
hdl/frontend_pkg.sv
hdl/pre_fetch_stage.sv
hdl/fetch_stage.sv
hdl/branch_predictor.sv
hdl/inst_rom.sv
hdl/frontend_top.sv
test/frontend_asserts.sv
test/frontend_tb.sv

// ==== hdl/branch_predictor.sv ====
`timescale 1ns/10ps

module branch_predictor (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         lookup_en,
    input  frontend_pkg::addr_t          lookup_pc,
    input  frontend_pkg::branch_result_t branch_result,
    output frontend_pkg::prediction_t    bp_hit
);
    import frontend_pkg::*;

    // ####################
    // btb storage
    logic [BTB_ENTRIES-1:0] btb_valid;
    btb_tag_t               btb_tag [BTB_ENTRIES];
    addr_t                  btb_target [BTB_ENTRIES];
    ctr_t                   btb_ctr [BTB_ENTRIES];

    logic [BTB_IDX_BITS-1:0] lk_idx;
    btb_tag_t                lk_tag;
    logic                    lk_hit;
    logic [BTB_IDX_BITS-1:0] up_idx;
    btb_tag_t                up_tag;
    logic                    up_match;
    ctr_t                    ctr_next;

    assign lk_idx = lookup_pc[BTB_IDX_BITS+1:2];
    assign lk_tag = lookup_pc[31:BTB_IDX_BITS+2];
    assign up_idx = branch_result.pc[BTB_IDX_BITS+1:2];
    assign up_tag = branch_result.pc[31:BTB_IDX_BITS+2];

    // taken only on a tag hit with the counter in a taken state
    assign lk_hit = btb_valid[lk_idx] && (btb_tag[lk_idx] == lk_tag)
                    && (btb_ctr[lk_idx] inside {weak_t, strong_t});
    assign up_match = btb_valid[up_idx] && (btb_tag[up_idx] == up_tag);

    // ####################
    // lookup, registered and held
    always_ff @(posedge clk) begin
        if (reset) begin
            bp_hit <= '0;
        end else if (lookup_en) begin
            bp_hit.taken  <= lk_hit;
            bp_hit.target <= lk_hit ? btb_target[lk_idx] : '0;
        end
    end

    // saturating step
    always_comb begin
        case (btb_ctr[up_idx])
            strong_nt: ctr_next = branch_result.taken ? weak_nt : strong_nt;
            weak_nt:   ctr_next = branch_result.taken ? weak_t : strong_nt;
            weak_t:    ctr_next = branch_result.taken ? strong_t : weak_nt;
            strong_t:  ctr_next = branch_result.taken ? strong_t : weak_t;
            default:   ctr_next = weak_t;
        endcase
    end

    // ####################
    // update from branch results
    always_ff @(posedge clk) begin
        if (reset) begin
            btb_valid <= '0;
        end else if (branch_result.valid && branch_result.taken && !up_match) begin
            btb_valid[up_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (branch_result.valid) begin
            if (up_match) begin
                btb_ctr[up_idx] <= ctr_next;
                if (branch_result.taken) begin
                    btb_target[up_idx] <= branch_result.target;
                end
            end else if (branch_result.taken) begin
                // allocate, a not-taken miss leaves the entry alone
                btb_tag[up_idx]    <= up_tag;
                btb_target[up_idx] <= branch_result.target;
                btb_ctr[up_idx]    <= weak_t;
            end
        end
    end

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ps_to_fs_valid,
    input  frontend_pkg::pre_to_fs_t  ps_to_fs,
    input  logic                      ds_allowin,
    input  logic                      flush,
    input  frontend_pkg::redirect_t   redirect,
    input  frontend_pkg::inst_t       inst_rdata,
    input  frontend_pkg::prediction_t bp_hit,
    output logic                      fs_allowin,
    output logic                      fs_to_ds_valid,
    output frontend_pkg::fs_to_ds_t   fs_to_ds,
    output frontend_pkg::prediction_t prediction
);
    import frontend_pkg::*;

    logic       fs_valid;
    logic       fs_fresh;
    pre_to_fs_t fs_item;
    logic       fs_enter;
    logic       fs_kill;
    logic       fs_pred_taken;

    assign fs_kill    = flush || redirect.valid;
    assign fs_enter   = ps_to_fs_valid && fs_allowin;
    // fetch never waits on memory
    assign fs_allowin = !fs_valid || ds_allowin;

    // ####################
    // pipeline register
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_kill) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= ps_to_fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_enter) begin
            fs_item <= ps_to_fs;
        end
    end

    // high only in the first cycle of an item
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_fresh <= 1'b0;
        end else begin
            fs_fresh <= fs_enter && !fs_kill;
        end
    end

    // ####################
    // output towards decode
    // rom word and predictor result are held since the entry edge
    assign fs_pred_taken  = bp_hit.taken && !fs_item.ex;
    assign fs_to_ds_valid = fs_valid;

    always_comb begin
        fs_to_ds.pc          = fs_item.pc;
        fs_to_ds.inst        = fs_item.ex ? '0 : inst_rdata;
        fs_to_ds.ex          = fs_item.ex;
        fs_to_ds.exc_code    = fs_item.ex ? EXC_ADEL : '0;
        fs_to_ds.pred_taken  = fs_pred_taken;
        fs_to_ds.pred_target = fs_pred_taken ? bp_hit.target : '0;
    end

    // steer pre-fetch once, even if decode stalls this item
    always_comb begin
        prediction.taken  = fs_valid && fs_fresh && fs_pred_taken;
        prediction.target = bp_hit.target;
    end

endmodule

// ==== hdl/frontend_pkg.sv ====
package frontend_pkg;

    // ####################
    // widths with a meaning
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  exc_code_t;

    // ####################
    // fixed addresses and codes
    localparam addr_t     RESET_PC   = 32'h0;
    localparam addr_t     EXC_VECTOR = 32'h80;
    localparam exc_code_t EXC_ADEL   = 5'h04;

    // memory and predictor geometry
    localparam int ROM_WORDS     = 64;
    localparam int ROM_ADDR_BITS = $clog2(ROM_WORDS);
    localparam int BTB_ENTRIES   = 16;
    localparam int BTB_IDX_BITS  = $clog2(BTB_ENTRIES);
    // tag is everything above the index and the byte offset
    localparam int BTB_TAG_BITS  = 32 - BTB_IDX_BITS - 2;

    typedef logic [BTB_TAG_BITS-1:0] btb_tag_t;

    // ####################
    // stage buses
    typedef struct packed {
        addr_t pc;
        logic  ex;
    } pre_to_fs_t;

    typedef struct packed {
        addr_t     pc;
        inst_t     inst;
        logic      ex;
        exc_code_t exc_code;
        logic      pred_taken;
        addr_t     pred_target;
    } fs_to_ds_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } prediction_t;

    // resolved branch from the back end
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
    } branch_result_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } redirect_t;

    // 2-bit saturating counter
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_t;

endpackage

// ==== hdl/frontend_top.sv ====
`timescale 1ns/10ps

module frontend_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ds_allowin,
    input  frontend_pkg::branch_result_t branch_result,
    input  frontend_pkg::redirect_t      redirect,
    input  logic                         flush,
    output logic                         fs_to_ds_valid,
    output frontend_pkg::fs_to_ds_t      fs_to_ds
);
    import frontend_pkg::*;

    logic        ps_to_fs_valid;
    pre_to_fs_t  ps_to_fs;
    logic        fs_allowin;
    prediction_t prediction;
    prediction_t bp_hit;
    inst_t       inst_rdata;
    logic        fetch_en;

    // rom and btb see the pc on the same edge fetch takes it
    assign fetch_en = ps_to_fs_valid && fs_allowin;

    // ####################
    // stages
    pre_fetch_stage i_pre_fetch (
        .clk            (clk),
        .reset          (reset),
        .fs_allowin     (fs_allowin),
        .prediction     (prediction),
        .redirect       (redirect),
        .flush          (flush),
        .ps_to_fs_valid (ps_to_fs_valid),
        .ps_to_fs       (ps_to_fs)
    );

    fetch_stage i_fetch (
        .clk            (clk),
        .reset          (reset),
        .ps_to_fs_valid (ps_to_fs_valid),
        .ps_to_fs       (ps_to_fs),
        .ds_allowin     (ds_allowin),
        .flush          (flush),
        .redirect       (redirect),
        .inst_rdata     (inst_rdata),
        .bp_hit         (bp_hit),
        .fs_allowin     (fs_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .prediction     (prediction)
    );

    // ####################
    // predictor and memory
    branch_predictor i_bpred (
        .clk           (clk),
        .reset         (reset),
        .lookup_en     (fetch_en),
        .lookup_pc     (ps_to_fs.pc),
        .branch_result (branch_result),
        .bp_hit        (bp_hit)
    );

    inst_rom i_rom (
        .clk   (clk),
        .en    (fetch_en),
        .addr  (ps_to_fs.pc),
        .rdata (inst_rdata)
    );

endmodule

// ==== hdl/inst_rom.sv ====
`timescale 1ns/10ps

module inst_rom (
    input  logic                clk,
    input  logic                en,
    input  frontend_pkg::addr_t addr,
    output frontend_pkg::inst_t rdata
);
    import frontend_pkg::*;

    inst_t                    mem [ROM_WORDS];
    logic [ROM_ADDR_BITS-1:0] word_idx;

    // program image
    initial begin
        $readmemh("program.hex", mem);
    end

    // word index, upper bits ignored so the address wraps
    assign word_idx = addr[ROM_ADDR_BITS+1:2];

    // ####################
    // synchronous read
    // output stays put until the next enabled edge
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[word_idx];
        end
    end

endmodule

// ==== hdl/pre_fetch_stage.sv ====
`timescale 1ns/10ps

module pre_fetch_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fs_allowin,
    input  frontend_pkg::prediction_t prediction,
    input  frontend_pkg::redirect_t   redirect,
    input  logic                      flush,
    output logic                      ps_to_fs_valid,
    output frontend_pkg::pre_to_fs_t  ps_to_fs
);
    import frontend_pkg::*;

    addr_t ps_pc;
    logic  ps_valid;
    logic  ps_go;

    // pc handed to fetch this cycle
    assign ps_go = ps_to_fs_valid && fs_allowin;

    // ####################
    // next pc selection
    always_ff @(posedge clk) begin
        if (reset) begin
            ps_pc    <= RESET_PC;
            ps_valid <= 1'b0;
        end else if (flush) begin
            // exception entry, pc offered from the next cycle on
            ps_pc    <= EXC_VECTOR;
            ps_valid <= 1'b0;
        end else if (redirect.valid) begin
            ps_pc    <= redirect.pc;
            ps_valid <= 1'b0;
        end else if (prediction.taken) begin
            // the fall-through pc waiting here is dropped
            ps_pc    <= prediction.target;
            ps_valid <= 1'b1;
        end else begin
            ps_valid <= 1'b1;
            if (ps_go) begin
                ps_pc <= ps_pc + 32'd4;
            end
        end
    end

    // ####################
    // bus towards fetch
    // no handoff while fetch is steering us to a target
    assign ps_to_fs_valid = ps_valid && !prediction.taken;

    always_comb begin
        ps_to_fs.pc = ps_pc;
        // misaligned fetch address
        ps_to_fs.ex = |ps_pc[1:0];
    end

endmodule

// ==== program.hex ====
// instruction words, four per line, word address rising left to right
24001000 24011004 24021008 2403100c
24041010 24051014 24061018 2407101c
24081020 24091024 240a1028 240b102c
240c1030 240d1034 240e1038 240f103c
24101040 24111044 24121048 2413104c
24141050 24151054 24161058 2417105c
24181060 24191064 241a1068 241b106c
241c1070 241d1074 241e1078 241f107c
24201080 24211084 24221088 2423108c
24241090 24251094 24261098 2427109c
242810a0 242910a4 242a10a8 242b10ac
242c10b0 242d10b4 242e10b8 242f10bc
243010c0 243110c4 243210c8 243310cc
243410d0 243510d4 243610d8 243710dc
243810e0 243910e4 243a10e8 243b10ec
243c10f0 243d10f4 243e10f8 243f10fc

// ==== test/frontend_asserts.sv ====
`timescale 1ns/10ps

module frontend_asserts (
    input logic                    clk,
    input logic                    reset,
    input logic                    ds_allowin,
    input logic                    flush,
    input frontend_pkg::redirect_t redirect,
    input logic                    ps_to_fs_valid,
    input logic                    fs_to_ds_valid,
    input frontend_pkg::fs_to_ds_t fs_to_ds
);

    // both stages empty right after a reset edge
    reset_clears_valid: assert property (@(posedge clk)
        reset |=> !ps_to_fs_valid && !fs_to_ds_valid)
        else $error("valid output high in the cycle after reset");

    // stalled item stays put unless killed
    stall_holds_output: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid && !ds_allowin && !flush && !redirect.valid
        |=> fs_to_ds_valid && $stable(fs_to_ds))
        else $error("fetch output moved while decode stalled");

    flush_stops_prefetch: assert property (@(posedge clk) disable iff (reset)
        flush |=> !ps_to_fs_valid)
        else $error("pre-fetch offered a pc right after a flush");

endmodule

bind frontend_top frontend_asserts i_asserts (
    .clk            (clk),
    .reset          (reset),
    .ds_allowin     (ds_allowin),
    .flush          (flush),
    .redirect       (redirect),
    .ps_to_fs_valid (ps_to_fs_valid),
    .fs_to_ds_valid (fs_to_ds_valid),
    .fs_to_ds       (fs_to_ds)
);

// ==== test/frontend_tb.sv ====
`timescale 1ns/10ps

module frontend_tb;
    import frontend_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int PHASE_ITEMS  = 20;
    // upper bound on the items all phases take together
    localparam int TOTAL_ITEMS  = 8 * PHASE_ITEMS;
    // about three cycles per item under random back-pressure
    localparam int TEST_CYCLES  = RESET_CYCLES + 20 + 3 * TOTAL_ITEMS;

    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        addr_t    target;
        ctr_t     ctr;
    } btb_entry_t;

    logic           clk;
    logic           reset;
    logic           ds_allowin;
    branch_result_t branch_result;
    redirect_t      redirect;
    logic           flush;
    logic           fs_to_ds_valid;
    fs_to_ds_t      fs_to_ds;

    inst_t                        rom_ref [ROM_WORDS];
    btb_entry_t [BTB_ENTRIES-1:0] btb_model;
    btb_entry_t [BTB_ENTRIES-1:0] entry_tbl;
    logic [31:0]                  lfsr_state = 32'h285a944a;

    // expected-order state, updated at each accepted transfer
    addr_t       last_pc = RESET_PC - 32'd4;
    prediction_t last_pred = '0;
    logic        pend_valid = 1'b0;
    addr_t       pend_pc = '0;
    logic        open_q = 1'b0;
    logic        stall_armed = 1'b0;
    fs_to_ds_t   stall_item;
    int          accepted = 0;
    int          pred_seen = 0;
    int          value_errors = 0;
    int          stall_errors = 0;
    int          other_errors = 0;

    frontend_top i_dut (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .branch_result  (branch_result),
        .redirect       (redirect),
        .flush          (flush),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ####################
    // random source and reference model
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);
    endfunction

    task automatic draw_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    // next pc follows pending redirect, then last prediction, then pc + 4
    function automatic fs_to_ds_t expected_fetch(input addr_t prev_pc,
                                                 input prediction_t prev_pred,
                                                 input logic redir_valid,
                                                 input addr_t redir_pc,
                                                 input btb_entry_t [BTB_ENTRIES-1:0] tbl);
        fs_to_ds_t  e;
        btb_entry_t ent;
        if (redir_valid) begin
            e.pc = redir_pc;
        end else if (prev_pred.taken) begin
            e.pc = prev_pred.target;
        end else begin
            e.pc = prev_pc + 32'd4;
        end
        e.ex = |e.pc[1:0];
        e.exc_code = e.ex ? EXC_ADEL : '0;
        e.inst = e.ex ? '0 : rom_ref[e.pc[ROM_ADDR_BITS+1:2]];
        ent = tbl[e.pc[BTB_IDX_BITS+1:2]];
        e.pred_taken = !e.ex && ent.valid && (ent.tag == e.pc[31:BTB_IDX_BITS+2])
                       && (ent.ctr inside {weak_t, strong_t});
        e.pred_target = e.pred_taken ? ent.target : '0;
        return e;
    endfunction

    task automatic update_model(input branch_result_t br);
        btb_entry_t e;
        e = btb_model[br.pc[BTB_IDX_BITS+1:2]];
        if (e.valid && e.tag == br.pc[31:BTB_IDX_BITS+2]) begin
            if (br.taken) begin
                e.target = br.target;
                if (e.ctr != strong_t) begin
                    e.ctr = ctr_t'(e.ctr + 2'd1);
                end
            end else if (e.ctr != strong_nt) begin
                e.ctr = ctr_t'(e.ctr - 2'd1);
            end
        end else if (br.taken) begin
            e.valid = 1'b1;
            e.tag = br.pc[31:BTB_IDX_BITS+2];
            e.target = br.target;
            e.ctr = weak_t;
        end
        btb_model[br.pc[BTB_IDX_BITS+1:2]] = e;
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("Fail %0t: %s is %h, expected %h", $time, name, got, want);
            value_errors++;
        end
    endtask

    // ####################
    // stimulus helpers
    task automatic tick();
        logic b0;
        logic b1;
        @(negedge clk);
        // an item that entered at the last edge saw the table from before that edge
        if (open_q && fs_to_ds_valid) begin
            entry_tbl = btb_model;
        end
        if (branch_result.valid) begin
            update_model(branch_result);
        end
        branch_result = '0;
        redirect = '0;
        flush = 1'b0;
        draw_bit(b0);
        draw_bit(b1);
        ds_allowin = b0 | b1;
    endtask

    task automatic run_items(input int n);
        int goal;
        goal = accepted + n;
        while (accepted < goal) begin
            tick();
        end
    endtask

    task automatic send_branch(input addr_t pc, input logic taken, input addr_t target);
        branch_result.valid = 1'b1;
        branch_result.pc = pc;
        branch_result.taken = taken;
        branch_result.target = target;
        tick();
    endtask

    task automatic send_redirect(input addr_t pc);
        redirect.valid = 1'b1;
        redirect.pc = pc;
        tick();
    endtask

    task automatic send_flush();
        flush = 1'b1;
        tick();
    endtask

    // ####################
    // compare at each accepted transfer
    always @(posedge clk) begin : compare
        fs_to_ds_t exp_item;
        if (!reset) begin
            if (stall_armed) begin
                assert (fs_to_ds_valid && fs_to_ds == stall_item) else begin
                    $display("output changed while stalled, at time %0t", $time);
                    stall_errors++;
                end
            end
            if (fs_to_ds_valid && ds_allowin) begin
                exp_item = expected_fetch(last_pc, last_pred, pend_valid, pend_pc, entry_tbl);
                check_field("pc", fs_to_ds.pc, exp_item.pc);
                check_field("inst", fs_to_ds.inst, exp_item.inst);
                check_field("ex", fs_to_ds.ex, exp_item.ex);
                check_field("exc_code", fs_to_ds.exc_code, exp_item.exc_code);
                check_field("pred_taken", fs_to_ds.pred_taken, exp_item.pred_taken);
                check_field("pred_target", fs_to_ds.pred_target, exp_item.pred_target);
                last_pc = exp_item.pc;
                last_pred.taken = exp_item.pred_taken;
                last_pred.target = exp_item.pred_target;
                pend_valid = 1'b0;
                accepted++;
                if (exp_item.pred_taken) begin
                    pred_seen++;
                end
            end
            stall_armed = fs_to_ds_valid && !ds_allowin && !flush && !redirect.valid;
            stall_item = fs_to_ds;
            if (flush) begin
                pend_valid = 1'b1;
                pend_pc = EXC_VECTOR;
            end else if (redirect.valid) begin
                pend_valid = 1'b1;
                pend_pc = redirect.pc;
            end
            open_q = !fs_to_ds_valid || ds_allowin;
        end
    end

    initial begin
        #(TEST_CYCLES * 10 + 200);
        $display("run timed out after %0d cycles", TEST_CYCLES);
        $display("sim failed");
        $finish;
    end

    // ####################
    // test sequence
    initial begin
        reset = 1'b1;
        ds_allowin = 1'b0;
        branch_result = '0;
        redirect = '0;
        flush = 1'b0;
        btb_model = '0;
        entry_tbl = '0;
        $readmemh("program.hex", rom_ref);

        repeat (RESET_CYCLES) begin
            tick();
            assert (!fs_to_ds_valid) else begin
                $display("fetch output valid while reset is high");
                other_errors++;
            end
        end
        reset = 1'b0;
        tick();
        assert (!fs_to_ds_valid) else begin
            $display("first item came one cycle after reset release");
            other_errors++;
        end
        tick();
        assert (fs_to_ds_valid && fs_to_ds.pc == RESET_PC) else begin
            $display("first item did not show two cycles after reset release");
            other_errors++;
        end

        // sequential fetch under random back-pressure
        run_items(2 * PHASE_ITEMS);

        // train 0x20 taken to 0x40 and fetch through it
        send_branch(32'h20, 1'b1, 32'h40);
        send_branch(32'h20, 1'b1, 32'h40);
        send_redirect(32'h10);
        run_items(PHASE_ITEMS);

        // two not-taken results stop the prediction
        send_branch(32'h20, 1'b0, 32'h0);
        send_branch(32'h20, 1'b0, 32'h0);
        send_redirect(32'h10);
        run_items(PHASE_ITEMS);

        send_redirect(32'h64);
        run_items(PHASE_ITEMS);
        // misaligned target gives exception items
        send_redirect(32'h32);
        run_items(6);

        send_flush();
        run_items(PHASE_ITEMS);

        // a branch in the exception handler, reached through a flush
        send_branch(32'h90, 1'b1, 32'h20);
        send_flush();
        run_items(PHASE_ITEMS);

        assert (pred_seen > 0) else begin
            $display("no predicted-taken item reached decode");
            other_errors++;
        end
        $display("errors: value %0d, stall %0d, other %0d", value_errors, stall_errors,
                 other_errors);
        if (value_errors + stall_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
